//--- sim.f
+incdir+logic
logic/lsu_op_pkg.sv
logic/mem_bus_pkg.sv
logic/mem_interface.sv
logic/data_ram.sv
logic/lsu_top.sv
test/lsu_checker.sv
test/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing -Wno-fatal -f sim.f --top-module lsu_tb \
    -Mdir "$BUILD_DIR" -o lsu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/lsu_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^sim passed$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- test/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_tb;
    import lsu_op_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int N_DIRECTED  = 61;  // Prefill and directed operations issued below.
    localparam int N_RANDOM    = 300;
    localparam int N_OPS       = N_DIRECTED + N_RANDOM;
    localparam int WATCHDOG_NS = N_OPS * (`LSU_RAM_WAIT + 4) * CLK_PERIOD + 40 * CLK_PERIOD;

    logic                   clk;
    logic                   rst;
    logic                   inst_valid;
    logic                   mem_read;
    logic                   mem_write;
    load_type_t             load_type;
    store_type_t            store_type;
    logic [`LSU_AWIDTH-1:0] addr;
    logic [`LSU_XLEN-1:0]   wdata;
    logic [`LSU_XLEN-1:0]   rdata;
    logic                   access_ok;
    logic                   access_err;
    logic [2:0]             test_id;
    int                     ops_issued;
    int                     tb_errors;
    int                     check_cnt;
    int                     value_err_cnt;
    int                     proto_err_cnt;
    int                     done_cnt;

    lsu_top u_lsu_top (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid),
        .mem_read_i   (mem_read),
        .mem_write_i  (mem_write),
        .load_type_i  (load_type),
        .store_type_i (store_type),
        .addr_i       (addr),
        .wdata_i      (wdata),
        .rdata_o      (rdata),
        .access_ok_o  (access_ok),
        .access_err_o (access_err)
    );

    lsu_checker u_checker (
        .clk             (clk),
        .rst             (rst),
        .inst_valid_i    (inst_valid),
        .mem_read_i      (mem_read),
        .mem_write_i     (mem_write),
        .load_type_i     (load_type),
        .store_type_i    (store_type),
        .addr_i          (addr),
        .wdata_i         (wdata),
        .rdata_i         (rdata),
        .access_ok_i     (access_ok),
        .access_err_i    (access_err),
        .test_id_i       (test_id),
        .check_cnt_o     (check_cnt),
        .value_err_cnt_o (value_err_cnt),
        .proto_err_cnt_o (proto_err_cnt),
        .done_cnt_o      (done_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Pulse the instruction, then hold the request until access_ok is seen.
    task automatic issue_access(input logic is_write, input load_type_t lt, input store_type_t st,
                                input logic [31:0] a, input logic [63:0] d);
        @(posedge clk);
        #1;
        inst_valid = 1'b1;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        load_type  = lt;
        store_type = st;
        addr       = a;
        wdata      = d;
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
        mem_read   = !is_write;
        mem_write  = is_write;
        do @(negedge clk); while (access_ok !== 1'b1);
        ops_issued++;
    endtask

    task automatic store_op(input store_type_t st, input logic [31:0] a, input logic [63:0] d);
        issue_access(1'b1, LD_NONE, st, a, d);
    endtask

    task automatic load_op(input load_type_t lt, input logic [31:0] a);
        issue_access(1'b0, lt, ST_NONE, a, '0);
    endtask

    task automatic print_counts();
        $display("Checks %0d, value errors %0d, protocol errors %0d, testbench errors %0d",
                 check_cnt, value_err_cnt, proto_err_cnt, tb_errors);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        print_counts();
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [31:0] a;
        void'($urandom(87));
        rst        = 1'b1;
        inst_valid = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        load_type  = LD_NONE;
        store_type = ST_NONE;
        addr       = '0;
        wdata      = '0;
        test_id    = 3'd0;
        ops_issued = 0;
        tb_errors  = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        test_id = 3'd5;
        repeat (4) @(posedge clk);  // Nothing is requested here and access_ok must stay low.

        test_id = 3'd0;  // Every byte used below gets a known value first.
        for (int w = 0; w < 16; w++) begin
            a = 32'(w * 8);
            store_op(ST_D, a, {32'hc0de_0000 | a, (a * 32'h0101_0101) ^ 32'h3c3c_3c3c});
        end

        test_id = 3'd5;  // The result must stay valid through idle cycles.
        store_op(ST_D, 32'h40, 64'h0f1e_2d3c_4b5a_6978);
        repeat (4) @(posedge clk);
        load_op(LD_D, 32'h40);

        test_id = 3'd1;
        store_op(ST_D, 32'h00, 64'h0123_4567_89ab_cdef);
        load_op(LD_D, 32'h00);
        store_op(ST_W, 32'h08, 64'h1111_2222_dead_beef);
        store_op(ST_W, 32'h0c, 64'hfeed_f00d);
        load_op(LD_WU, 32'h08);
        load_op(LD_WU, 32'h0c);
        store_op(ST_H, 32'h12, 64'h9abc);
        store_op(ST_H, 32'h16, 64'h5555_1234);
        load_op(LD_HU, 32'h12);
        load_op(LD_HU, 32'h16);
        store_op(ST_B, 32'h19, 64'ha5);
        store_op(ST_B, 32'h1f, 64'h3c);
        load_op(LD_BU, 32'h19);
        load_op(LD_BU, 32'h1f);

        test_id = 3'd2;
        store_op(ST_W, 32'h20, 64'h8000_1234);
        store_op(ST_W, 32'h24, 64'h1234_5678);
        load_op(LD_W, 32'h20);
        load_op(LD_WU, 32'h20);
        load_op(LD_W, 32'h24);
        load_op(LD_WU, 32'h24);
        store_op(ST_H, 32'h28, 64'h8abc);
        store_op(ST_H, 32'h2a, 64'h7abc);
        load_op(LD_H, 32'h28);
        load_op(LD_HU, 32'h28);
        load_op(LD_H, 32'h2a);
        load_op(LD_HU, 32'h2a);
        store_op(ST_B, 32'h2c, 64'h80);
        store_op(ST_B, 32'h2d, 64'h7f);
        load_op(LD_B, 32'h2c);
        load_op(LD_BU, 32'h2c);
        load_op(LD_B, 32'h2d);
        load_op(LD_BU, 32'h2d);

        test_id = 3'd3;
        store_op(ST_D, 32'h30, 64'h0011_2233_4455_6677);
        store_op(ST_B, 32'h35, 64'hee);
        load_op(LD_D, 32'h30);

        test_id = 3'd4;
        load_op(LD_H, 32'h31);
        load_op(LD_W, 32'h32);
        load_op(LD_D, 32'h34);
        store_op(ST_D, 32'h38, 64'h8899_aabb_ccdd_eeff);
        store_op(ST_H, 32'h39, 64'h1111);
        store_op(ST_W, 32'h3a, 64'h2222_2222);
        store_op(ST_D, 32'h3c, 64'h3333_3333_3333_3333);
        load_op(LD_D, 32'h38);

        test_id = 3'd6;  // Addresses stay inside the prefilled region.
        for (int i = 0; i < N_RANDOM; i++) begin
            a = $urandom % 128;
            if ($urandom % 2) begin
                store_op(store_type_t'({1'b1, 2'($urandom % 4)}), a, {$urandom, $urandom});
            end else begin
                load_op(load_type_t'(3'(1 + $urandom % 7)), a);
            end
        end

        repeat (3) @(posedge clk);
        if (done_cnt != ops_issued) begin
            tb_errors++;
            $display("Completion count %0d does not match %0d issued requests",
                     done_cnt, ops_issued);
        end
        print_counts();
        if (tb_errors == 0 && value_err_cnt == 0 && proto_err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/lsu_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_checker (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     inst_valid_i,
    input  wire                     mem_read_i,
    input  wire                     mem_write_i,
    input  wire [2:0]               load_type_i,
    input  wire [2:0]               store_type_i,
    input  wire [`LSU_AWIDTH-1:0]   addr_i,
    input  wire [`LSU_XLEN-1:0]     wdata_i,
    input  wire [`LSU_XLEN-1:0]     rdata_i,
    input  wire                     access_ok_i,
    input  wire                     access_err_i,
    input  wire [2:0]               test_id_i,
    output int                      check_cnt_o,
    output int                      value_err_cnt_o,
    output int                      proto_err_cnt_o,
    output int                      done_cnt_o
);
    localparam int MODEL_BYTES = `LSU_RAM_WORDS * 8;

    logic [7:0]                 model_mem [MODEL_BYTES];
    logic                       armed;     // An instruction pulse was seen.
    logic                       captured;  // Its request fields are recorded.
    logic                       ok_q;
    logic                       req_write;
    logic [2:0]                 req_ltype;
    logic [2:0]                 req_stype;
    logic [`LSU_AWIDTH-1:0]     req_addr;
    logic [`LSU_XLEN-1:0]       req_wdata;

    function automatic string test_label(input logic [2:0] id);
        case (id)
            3'd0:    return "prefill";
            3'd1:    return "store_load";
            3'd2:    return "sign_extend";
            3'd3:    return "lane_isolation";
            3'd4:    return "misaligned";
            3'd5:    return "sequencing";
            default: return "random";
        endcase
    endfunction

    function automatic int load_bytes(input logic [2:0] lt);
        case (lt)
            3'b001, 3'b101: return 1;
            3'b010, 3'b110: return 2;
            3'b011, 3'b111: return 4;
            3'b100:         return 8;
            default:        return 0;
        endcase
    endfunction

    // Expected load result, taken from the byte model in little-endian order.
    function automatic logic [63:0] expect_load(input logic [31:0] a, input logic [2:0] lt,
                                                output logic err);
        int          n;
        logic [63:0] val;
        logic [31:0] ba;
        n   = load_bytes(lt);
        val = '0;
        err = 1'b0;
        if (n == 0) return '0;
        if ((a % n) != 0) begin
            err = 1'b1;
            return '0;
        end
        for (int i = 0; i < n; i++) begin
            ba = (a + i) % MODEL_BYTES;
            val[i*8 +: 8] = model_mem[ba];
        end
        if (!lt[2] && lt != 3'b000 && val[n*8-1]) begin  // Signed codes are 001 to 011.
            for (int i = n; i < 8; i++) val[i*8 +: 8] = 8'hff;
        end
        return val;
    endfunction

    task automatic apply_store(input logic [31:0] a, input logic [2:0] st,
                               input logic [63:0] d, output logic err);
        int          n;
        logic [31:0] ba;
        n   = 1 << st[1:0];
        err = (a % n) != 0;
        if (!err) begin
            for (int i = 0; i < n; i++) begin
                ba = (a + i) % MODEL_BYTES;
                model_mem[ba] = d[i*8 +: 8];
            end
        end
    endtask

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        check_cnt_o++;
        if (exp !== act) begin
            value_err_cnt_o++;
            $display("Fail %s: %s at addr %h expected %h actual %h",
                     test_label(test_id_i), what, req_addr, exp, act);
        end
    endtask

    task automatic compare_completion();
        logic        exp_err;
        logic [63:0] exp_data;
        if (req_write) begin
            apply_store(req_addr, req_stype, req_wdata, exp_err);
            check_value("store error flag", 64'(exp_err), 64'(access_err_i));
        end else begin
            exp_data = expect_load(req_addr, req_ltype, exp_err);
            check_value("load data", exp_data, rdata_i);
            check_value("load error flag", 64'(exp_err), 64'(access_err_i));
        end
    endtask

    // Sampled on the falling edge, where inputs and outputs are both settled.
    always @(negedge clk) begin
        if (rst) begin
            armed           = 1'b0;
            captured        = 1'b0;
            ok_q            = 1'b0;
            check_cnt_o     = 0;
            value_err_cnt_o = 0;
            proto_err_cnt_o = 0;
            done_cnt_o      = 0;
        end else begin
            if (access_ok_i && !ok_q) begin
                if (!captured) begin
                    proto_err_cnt_o++;
                    $display("Protocol error: access_ok rose without a request");
                end else begin
                    compare_completion();
                    done_cnt_o++;
                end
                armed    = 1'b0;
                captured = 1'b0;
            end
            if (ok_q && !access_ok_i && !armed) begin
                proto_err_cnt_o++;
                $display("Protocol error: access_ok dropped before the next instruction");
            end
            if (inst_valid_i) begin
                if (captured) begin
                    proto_err_cnt_o++;
                    $display("Protocol error: new instruction while an access was pending");
                end
                armed    = 1'b1;
                captured = 1'b0;
            end
            if (armed && !captured && (mem_read_i || mem_write_i)) begin
                captured  = 1'b1;
                req_write = mem_write_i;
                req_ltype = load_type_i;
                req_stype = store_type_i;
                req_addr  = addr_i;
                req_wdata = wdata_i;
            end
            ok_q = access_ok_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_top (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            inst_valid_i,
    input  wire                            mem_read_i,
    input  wire                            mem_write_i,
    input  lsu_op_pkg::load_type_t         load_type_i,
    input  lsu_op_pkg::store_type_t        store_type_i,
    input  wire [`LSU_AWIDTH-1:0]          addr_i,
    input  wire [`LSU_XLEN-1:0]            wdata_i,
    output logic [`LSU_XLEN-1:0]           rdata_o,
    output logic                           access_ok_o,
    output logic                           access_err_o
);
    import mem_bus_pkg::*;

    logic                       bus_valid;
    logic [`LSU_AWIDTH-1:0]     bus_addr;
    access_size_t               bus_size;
    req_kind_t                  bus_req;
    logic [`LSU_XLEN-1:0]       bus_wdata;
    logic                       bus_ready;
    logic [`LSU_XLEN-1:0]       bus_rdata;
    bus_resp_t                  bus_resp;

    mem_interface u_mem_interface (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid_i),
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .load_type_i  (load_type_i),
        .store_type_i (store_type_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .rdata_o      (rdata_o),
        .access_ok_o  (access_ok_o),
        .access_err_o (access_err_o),
        .bus_valid_o  (bus_valid),
        .bus_addr_o   (bus_addr),
        .bus_size_o   (bus_size),
        .bus_req_o    (bus_req),
        .bus_wdata_o  (bus_wdata),
        .bus_ready_i  (bus_ready),
        .bus_rdata_i  (bus_rdata),
        .bus_resp_i   (bus_resp)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .rst     (rst),
        .valid_i (bus_valid),
        .addr_i  (bus_addr),
        .size_i  (bus_size),
        .req_i   (bus_req),
        .wdata_i (bus_wdata),
        .ready_o (bus_ready),
        .rdata_o (bus_rdata),
        .resp_o  (bus_resp)
    );

endmodule

`default_nettype wire

//--- logic/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module data_ram (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            valid_i,
    input  wire [`LSU_AWIDTH-1:0]          addr_i,
    input  mem_bus_pkg::access_size_t      size_i,
    input  mem_bus_pkg::req_kind_t         req_i,
    input  wire [`LSU_XLEN-1:0]            wdata_i,
    output logic                           ready_o,
    output logic [`LSU_XLEN-1:0]           rdata_o,
    output mem_bus_pkg::bus_resp_t         resp_o
);
    import mem_bus_pkg::*;

    localparam int XLEN   = `LSU_XLEN;
    localparam int NBYTES = XLEN / 8;
    localparam int WORDS  = `LSU_RAM_WORDS;
    localparam int IDX_W  = $clog2(WORDS);
    localparam int WAIT   = `LSU_RAM_WAIT;
    localparam int CNT_W  = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

    logic [XLEN-1:0]    mem [WORDS];
    logic [CNT_W-1:0]   wait_cnt;
    logic [IDX_W-1:0]   idx;
    logic [2:0]         offset;
    logic               misaligned;
    logic [NBYTES-1:0]  size_strb;
    logic [NBYTES-1:0]  strobe;
    logic [XLEN-1:0]    size_mask;
    logic [XLEN-1:0]    shifted;

    assign idx    = addr_i[IDX_W+2:3];
    assign offset = addr_i[2:0];

    // Ready follows valid once the wait count is reached.
    assign ready_o = valid_i && (wait_cnt == CNT_W'(WAIT));

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (!valid_i || ready_o) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_comb begin
        case (size_i)
            SIZE_B: begin
                misaligned = 1'b0;
                size_strb  = NBYTES'(8'h01);
                size_mask  = XLEN'(8'hff);
            end
            SIZE_H: begin
                misaligned = offset[0];
                size_strb  = NBYTES'(8'h03);
                size_mask  = XLEN'(16'hffff);
            end
            SIZE_W: begin
                misaligned = |offset[1:0];
                size_strb  = NBYTES'(8'h0f);
                size_mask  = XLEN'(32'hffff_ffff);
            end
            default: begin
                misaligned = |offset;
                size_strb  = '1;
                size_mask  = '1;
            end
        endcase
    end

    assign strobe  = size_strb << offset;
    assign shifted = mem[idx] >> {offset, 3'b000};  // Bring the addressed byte down to bit 0.

    always_comb begin
        if (misaligned) begin
            resp_o  = RESP_ERR;
            rdata_o = '0;
        end else begin
            resp_o  = RESP_OKAY;
            rdata_o = shifted & size_mask;
        end
    end

    // Only lanes selected by the strobe change.
    always_ff @(posedge clk) begin
        if (valid_i && ready_o && req_i == REQ_WRITE && !misaligned) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (strobe[b]) begin
                    mem[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_interface.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module mem_interface (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            inst_valid_i,
    input  wire                            mem_read_i,
    input  wire                            mem_write_i,
    input  lsu_op_pkg::load_type_t         load_type_i,
    input  lsu_op_pkg::store_type_t        store_type_i,
    input  wire [`LSU_AWIDTH-1:0]          addr_i,
    input  wire [`LSU_XLEN-1:0]            wdata_i,
    output logic [`LSU_XLEN-1:0]           rdata_o,
    output logic                           access_ok_o,
    output logic                           access_err_o,
    output logic                           bus_valid_o,
    output logic [`LSU_AWIDTH-1:0]         bus_addr_o,
    output mem_bus_pkg::access_size_t      bus_size_o,
    output mem_bus_pkg::req_kind_t         bus_req_o,
    output logic [`LSU_XLEN-1:0]           bus_wdata_o,
    input  wire                            bus_ready_i,
    input  wire [`LSU_XLEN-1:0]            bus_rdata_i,
    input  mem_bus_pkg::bus_resp_t         bus_resp_i
);
    import lsu_op_pkg::*;
    import mem_bus_pkg::*;

    localparam int XLEN = `LSU_XLEN;

    logic               store_eff;
    access_size_t       store_size;
    access_size_t       load_size;
    logic               load_active;
    logic               load_signed;
    logic               sign_bit;
    logic [XLEN-1:0]    load_mask;
    logic               finished;
    logic               handshake;
    logic [XLEN-1:0]    read_data_r;
    logic               err_r;

    assign store_eff  = store_type_i[2];
    assign store_size = access_size_t'(store_type_i[1:0]);

    always_comb begin
        load_size   = SIZE_B;
        load_signed = 1'b0;
        load_active = 1'b1;
        case (load_type_i)
            LD_B:    load_signed = 1'b1;
            LD_H:    begin load_size = SIZE_H; load_signed = 1'b1; end
            LD_W:    begin load_size = SIZE_W; load_signed = 1'b1; end
            LD_D:    load_size = SIZE_D;
            LD_BU:   load_size = SIZE_B;
            LD_HU:   load_size = SIZE_H;
            LD_WU:   load_size = SIZE_W;
            default: load_active = 1'b0;  // No load selected.
        endcase
    end

    // Request side of the handshake.
    assign bus_valid_o = (mem_read_i | mem_write_i) & ~finished;
    assign bus_addr_o  = addr_i;
    assign bus_wdata_o = wdata_i << {addr_i[2:0], 3'b000};  // Move data into its byte lanes.
    assign handshake   = bus_valid_o & bus_ready_i;

    always_comb begin
        if (mem_write_i && store_eff) begin
            bus_size_o = store_size;
            bus_req_o  = REQ_WRITE;
        end else begin
            bus_size_o = load_size;
            bus_req_o  = REQ_READ;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            read_data_r <= '0;
            err_r       <= 1'b0;
        end else if (handshake) begin
            err_r <= (bus_resp_i == RESP_ERR);
            if (mem_read_i) begin
                read_data_r <= bus_rdata_i;
            end
        end
    end

    // A new instruction takes priority over a transfer in the same cycle.
    always_ff @(posedge clk) begin
        if (rst || inst_valid_i) begin
            finished <= 1'b0;
        end else if (handshake) begin
            finished <= 1'b1;
        end
    end

    always_comb begin
        case (load_size)
            SIZE_B:  begin load_mask = XLEN'(8'hff);        sign_bit = read_data_r[7];  end
            SIZE_H:  begin load_mask = XLEN'(16'hffff);     sign_bit = read_data_r[15]; end
            SIZE_W:  begin load_mask = XLEN'(32'hffff_ffff); sign_bit = read_data_r[31]; end
            default: begin load_mask = '1;                  sign_bit = read_data_r[XLEN-1]; end
        endcase
        if (!load_active) begin
            load_mask = '0;
        end
    end

    // Signed loads fill everything above the loaded size with its top bit.
    assign rdata_o = (read_data_r & load_mask) |
                     ({XLEN{load_signed & sign_bit}} & ~load_mask);

    assign access_ok_o  = finished;
    assign access_err_o = err_r;

endmodule

`default_nettype wire

//--- logic/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    // Number of bytes moved by one bus transfer.
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } access_size_t;

    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_kind_t;

    // Response returned with ready, error on a misaligned access.
    typedef enum logic [1:0] {
        RESP_OKAY = 2'b00,
        RESP_ERR  = 2'b10
    } bus_resp_t;

endpackage

`default_nettype wire

//--- logic/lsu_op_pkg.sv
`default_nettype none

package lsu_op_pkg;

    // Load type code of the instruction.
    // Bit 2 marks unsigned sub-word loads, except 100 which is the doubleword load.
    typedef enum logic [2:0] {
        LD_NONE = 3'b000,  // No load.
        LD_B    = 3'b001,  // Signed byte.
        LD_H    = 3'b010,  // Signed half.
        LD_W    = 3'b011,  // Signed word.
        LD_D    = 3'b100,  // Doubleword.
        LD_BU   = 3'b101,  // Unsigned byte.
        LD_HU   = 3'b110,  // Unsigned half.
        LD_WU   = 3'b111   // Unsigned word.
    } load_type_t;

    // Store type code of the instruction.
    // Bit 2 says the store is effective, bits 1:0 give the size.
    typedef enum logic [2:0] {
        ST_NONE = 3'b000,
        ST_B    = 3'b100,
        ST_H    = 3'b101,
        ST_W    = 3'b110,
        ST_D    = 3'b111
    } store_type_t;

endpackage

`default_nettype wire

//--- logic/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Data path width of the core in bits.
`define LSU_XLEN 64

// Byte address width on the CPU side and on the memory bus.
`define LSU_AWIDTH 32

// Depth of the data RAM in XLEN-wide words. Higher address bits are ignored.
`define LSU_RAM_WORDS 256

// Cycles that valid must stay high before the RAM answers with ready.
`define LSU_RAM_WAIT 2

`endif
